// ==== hw/imm_ctrl_if.sv ====
`default_nettype none

interface imm_ctrl_if;

   logic       cnt_en;      // Shift cycle
   logic       cnt_done;    // Bit 31 cycle
   logic       load;        // Accepted strobe
   logic [3:0] immdec_en;   // Per-register shift enables
   logic [3:0] ctrl;        // Source selects
   logic       csr_imm_en;  // Zero sign for zimm

   modport counter (
      output cnt_en, cnt_done, load
   );

   modport fmt (
      input  load,
      output immdec_en, ctrl, csr_imm_en
   );

   modport dec (
      input cnt_en, cnt_done, load, immdec_en, ctrl, csr_imm_en
   );

endinterface

`default_nettype wire

// ==== hw/imm_fmt_decode.sv ====
`default_nettype none

module imm_fmt_decode (
   input  logic                        i_clk,
   input  logic                        i_rst_n,
   input  serial_imm_pkg::instr_word_t i_instr,
   imm_ctrl_if.fmt                     ctrl
);

   logic [2:0] fmt_next;
   logic [2:0] fmt_q;

   always_comb begin
      case (i_instr.r.opcode)
         serial_imm_pkg::OPC_LUI,
         serial_imm_pkg::OPC_AUIPC:  fmt_next = serial_imm_pkg::FMT_U;
         serial_imm_pkg::OPC_JAL:    fmt_next = serial_imm_pkg::FMT_J;
         serial_imm_pkg::OPC_JALR,
         serial_imm_pkg::OPC_LOAD,
         serial_imm_pkg::OPC_OPIMM:  fmt_next = serial_imm_pkg::FMT_I;
         serial_imm_pkg::OPC_STORE:  fmt_next = serial_imm_pkg::FMT_S;
         serial_imm_pkg::OPC_BRANCH: fmt_next = serial_imm_pkg::FMT_B;
         serial_imm_pkg::OPC_SYSTEM: begin
            // funct3[2] marks CSRRWI/CSRRSI/CSRRCI
            fmt_next = i_instr.i.funct3[2] ? serial_imm_pkg::FMT_CSRI : serial_imm_pkg::FMT_I;
         end
         default:                    fmt_next = serial_imm_pkg::FMT_R;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         fmt_q <= serial_imm_pkg::FMT_R;
      end else if (ctrl.load) begin
         fmt_q <= fmt_next;
      end
   end

   // immdec_en: [3] imm30_25, [2] imm24_20, [1] imm19_12_20, [0] imm11_7
   // ctrl[1] low also means an even immediate, so bit 0 is masked
   // ctrl[3] low only for U, which masks bits 11..0
   always_comb begin
      ctrl.immdec_en  = 4'b1100;  // I and R
      ctrl.ctrl       = 4'b1010;
      ctrl.csr_imm_en = 1'b0;
      case (fmt_q)
         serial_imm_pkg::FMT_S: begin
            ctrl.immdec_en = 4'b1001;
            ctrl.ctrl      = 4'b1011;  // Low field from imm11_7
         end
         serial_imm_pkg::FMT_B: begin
            ctrl.immdec_en = 4'b1001;
            ctrl.ctrl      = 4'b1101;  // Bit 7 lands on bit 11
         end
         serial_imm_pkg::FMT_U: begin
            ctrl.immdec_en = 4'b1110;
            ctrl.ctrl      = 4'b0000;  // Bits 30..20 recirculate
         end
         serial_imm_pkg::FMT_J: begin
            ctrl.immdec_en = 4'b1110;
            ctrl.ctrl      = 4'b1000;
         end
         serial_imm_pkg::FMT_CSRI: begin
            ctrl.immdec_en  = 4'b1110;  // rs1 field shifts out as zimm
            ctrl.ctrl       = 4'b1010;
            ctrl.csr_imm_en = 1'b1;
         end
         default: begin
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== hw/serial_bit_counter.sv ====
`default_nettype none

module serial_bit_counter (
   input  logic        i_clk,
   input  logic        i_rst_n,
   input  logic        i_instr_stb,
   output logic        o_busy,
   imm_ctrl_if.counter ctrl
);

   logic [1:0] state;
   logic [4:0] bit_idx;
   logic       last_bit;

   assign last_bit      = (bit_idx == 5'(serial_imm_pkg::XLEN - 1));
   assign o_busy        = (state != serial_imm_pkg::ST_IDLE);
   assign ctrl.load     = i_instr_stb & ~o_busy;  // Strobes while busy are dropped
   assign ctrl.cnt_en   = (state == serial_imm_pkg::ST_SHIFT);
   assign ctrl.cnt_done = ctrl.cnt_en & last_bit;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state   <= serial_imm_pkg::ST_IDLE;
         bit_idx <= '0;
      end else begin
         case (state)
            serial_imm_pkg::ST_IDLE: begin
               if (ctrl.load) begin
                  state <= serial_imm_pkg::ST_ADDR;
               end
            end
            serial_imm_pkg::ST_ADDR: begin
               state   <= serial_imm_pkg::ST_SHIFT;  // Addresses out this cycle
               bit_idx <= '0;
            end
            serial_imm_pkg::ST_SHIFT: begin
               bit_idx <= bit_idx + 5'd1;
               if (last_bit) begin
                  state <= serial_imm_pkg::ST_IDLE;
               end
            end
            default: begin
               state <= serial_imm_pkg::ST_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== hw/serial_imm_pkg.sv ====
`default_nettype none

package serial_imm_pkg;

   localparam int XLEN = 32;  // Serial bit cycles per immediate

   // RV32I major opcodes
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_JALR   = 7'b1100111;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

   localparam logic [2:0] FMT_R    = 3'd0;
   localparam logic [2:0] FMT_I    = 3'd1;
   localparam logic [2:0] FMT_S    = 3'd2;
   localparam logic [2:0] FMT_B    = 3'd3;
   localparam logic [2:0] FMT_U    = 3'd4;
   localparam logic [2:0] FMT_J    = 3'd5;
   localparam logic [2:0] FMT_CSRI = 3'd6;  // SYSTEM with zimm operand

   // Bit counter FSM states
   localparam logic [1:0] ST_IDLE  = 2'd0;
   localparam logic [1:0] ST_ADDR  = 2'd1;
   localparam logic [1:0] ST_SHIFT = 2'd2;

   typedef union packed {
      logic [31:0] raw;
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r;
      struct packed {
         logic [11:0] imm11_0;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } i;
      struct packed {
         logic [6:0] immhi;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] immlo;
         logic [6:0] opcode;
      } sb;
      struct packed {
         logic [19:0] imm31_12;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } uj;
   } instr_word_t;

endpackage

`default_nettype wire

// ==== hw/serial_imm_top.sv ====
`default_nettype none

module serial_imm_top #(
   parameter int SHARED_RFADDR_IMM_REGS = 1
) (
   input  logic        i_clk,
   input  logic        i_rst_n,
   input  logic        i_instr_stb,
   input  logic [31:0] i_instr,
   output logic        o_busy,
   output logic        o_addr_valid,
   output logic [4:0]  o_rs1_addr,
   output logic [4:0]  o_rs2_addr,
   output logic [4:0]  o_rd_addr,
   output logic        o_imm_valid,
   output logic        o_imm,
   output logic        o_csr_imm,
   output logic        o_imm_last
);

   imm_ctrl_if imm_ctrl ();

   serial_bit_counter u_bit_counter (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_instr_stb (i_instr_stb),
      .o_busy      (o_busy),
      .ctrl        (imm_ctrl.counter)
   );

   imm_fmt_decode u_fmt_decode (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_instr (i_instr),
      .ctrl    (imm_ctrl.fmt)
   );

   serial_immdec #(
      .SHARED_RFADDR_IMM_REGS (SHARED_RFADDR_IMM_REGS)
   ) u_immdec (
      .i_clk      (i_clk),
      .i_instr    (i_instr),
      .ctrl       (imm_ctrl.dec),
      .o_rs1_addr (o_rs1_addr),
      .o_rs2_addr (o_rs2_addr),
      .o_rd_addr  (o_rd_addr),
      .o_imm      (o_imm),
      .o_csr_imm  (o_csr_imm)
   );

   assign o_addr_valid = o_busy & ~imm_ctrl.cnt_en;  // Busy but not yet shifting
   assign o_imm_valid  = imm_ctrl.cnt_en;
   assign o_imm_last   = imm_ctrl.cnt_done;

endmodule

`default_nettype wire

// ==== hw/serial_immdec.sv ====
`default_nettype none

module serial_immdec #(
   parameter int SHARED_RFADDR_IMM_REGS = 1
) (
   input  logic                        i_clk,
   input  serial_imm_pkg::instr_word_t i_instr,
   imm_ctrl_if.dec                     ctrl,
   output logic [4:0]                  o_rs1_addr,
   output logic [4:0]                  o_rs2_addr,
   output logic [4:0]                  o_rd_addr,
   output logic                        o_imm,
   output logic                        o_csr_imm
);

   logic        imm31;
   logic [8:0]  imm19_12_20;
   logic        imm7;
   logic [5:0]  imm30_25;
   logic [4:0]  imm24_20;
   logic [4:0]  imm11_7;
   logic [11:0] low_mask;  // Thermometer over the first 12 shift cycles
   logic        signbit;
   logic        zero_low;
   logic        upper_in;
   logic        mid_in;

   assign signbit   = imm31 & ~ctrl.csr_imm_en;  // zimm is zero-extended
   assign o_csr_imm = imm19_12_20[4];

   assign upper_in = ctrl.ctrl[3] ? signbit : imm24_20[0];

   always_comb begin
      if (ctrl.ctrl[2]) begin
         mid_in = imm7;
      end else if (ctrl.ctrl[1]) begin
         mid_in = signbit;
      end else begin
         mid_in = imm19_12_20[0];
      end
   end

   always_ff @(posedge i_clk) begin
      if (ctrl.load) begin
         imm31       <= i_instr.sb.immhi[6];
         imm19_12_20 <= {i_instr.raw[19:12], i_instr.raw[20]};
         imm7        <= i_instr.raw[7];
         imm30_25    <= i_instr.sb.immhi[5:0];
         imm24_20    <= i_instr.r.rs2;
         imm11_7     <= i_instr.sb.immlo;
         low_mask    <= '1;
      end else if (ctrl.cnt_en) begin
         imm7     <= signbit;
         low_mask <= {1'b0, low_mask[11:1]};
         if (ctrl.immdec_en[1])
            imm19_12_20 <= {upper_in, imm19_12_20[8:1]};
         if (ctrl.immdec_en[3])
            imm30_25 <= {mid_in, imm30_25[5:1]};
         if (ctrl.immdec_en[2])
            imm24_20 <= {imm30_25[0], imm24_20[4:1]};
         if (ctrl.immdec_en[0])
            imm11_7 <= {imm30_25[0], imm11_7[4:1]};
      end
   end

   generate
      if (SHARED_RFADDR_IMM_REGS != 0) begin : g_shared
         // Addresses only hold during the address cycle
         assign o_rs1_addr = imm19_12_20[8:4];
         assign o_rs2_addr = imm24_20;
         assign o_rd_addr  = imm11_7;
      end else begin : g_split
         logic [4:0] rs1_q;
         logic [4:0] rs2_q;
         logic [4:0] rd_q;

         always_ff @(posedge i_clk) begin
            if (ctrl.load) begin
               rs1_q <= i_instr.r.rs1;
               rs2_q <= i_instr.r.rs2;
               rd_q  <= i_instr.r.rd;
            end
         end

         assign o_rs1_addr = rs1_q;
         assign o_rs2_addr = rs2_q;
         assign o_rd_addr  = rd_q;
      end
   endgenerate

   // Bit 0 of B/J and bits 11..0 of U
   assign zero_low = (~ctrl.ctrl[1] & low_mask[11]) | (~ctrl.ctrl[3] & low_mask[0]);

   always_comb begin
      if (ctrl.cnt_done) begin
         o_imm = signbit;
      end else if (zero_low) begin
         o_imm = 1'b0;
      end else if (ctrl.ctrl[0]) begin
         o_imm = imm11_7[0];  // S and B low field
      end else begin
         o_imm = imm24_20[0];
      end
   end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_serial_imm -f tb.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulator exited with status $status"
   exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
   exit 0
fi
exit 1

// ==== tb.f ====
hw/serial_imm_pkg.sv
hw/imm_ctrl_if.sv
hw/imm_fmt_decode.sv
hw/serial_bit_counter.sv
hw/serial_immdec.sv
hw/serial_imm_top.sv
verif/tb_serial_imm.sv

// ==== verif/tb_serial_imm.sv ====
`default_nettype none

module tb_serial_imm;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int WAIT_LIMIT = 200;  // Cycles per wait loop

   logic        i_clk;
   logic        i_rst_n;
   logic        i_instr_stb;
   logic [31:0] i_instr;
   logic        o_busy;
   logic        o_addr_valid;
   logic [4:0]  o_rs1_addr;
   logic [4:0]  o_rs2_addr;
   logic [4:0]  o_rd_addr;
   logic        o_imm_valid;
   logic        o_imm;
   logic        o_csr_imm;
   logic        o_imm_last;

   logic [15:0] lfsr_state;
   logic [31:0] exp_imm;
   logic [31:0] exp_mask;  // Bits of the stream that are defined
   logic [31:0] coll_imm;
   logic [4:0]  exp_rs1;
   logic [4:0]  exp_rs2;
   logic [4:0]  exp_rd;
   logic [4:0]  exp_zimm;
   logic [4:0]  coll_zimm;
   logic        csr_test;
   logic        stb_expected;  // Strobe the idle unit has to take
   logic        timed_out;
   logic        accepted_q;  // Strobe taken at the last edge
   logic        valid_q;
   logic [5:0]  bit_cnt;    // Valid bits seen since the accepted strobe
   int          err_cnt;
   int          test_cnt;
   int          fail_cnt;

   serial_imm_top #(.SHARED_RFADDR_IMM_REGS(1)) u_serial_imm_top (.*);

   always #10 i_clk = ~i_clk;

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int k = 0; k < n; k++) begin
         v          = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   function automatic logic [31:0] ref_imm(input serial_imm_pkg::instr_word_t w,
                                           input logic [2:0] fmt);
      logic [31:0] r;
      r = w.raw;
      case (fmt)
         serial_imm_pkg::FMT_I: return {{20{r[31]}}, w.i.imm11_0};
         serial_imm_pkg::FMT_S: return {{20{r[31]}}, w.sb.immhi, w.sb.immlo};
         serial_imm_pkg::FMT_B: return {{20{r[31]}}, r[7], r[30:25], r[11:8], 1'b0};
         serial_imm_pkg::FMT_U: return {w.uj.imm31_12, 12'h000};
         serial_imm_pkg::FMT_J: return {{12{r[31]}}, r[19:12], r[20], r[30:21], 1'b0};
         default:               return 32'h0;  // zimm words keep a zero sign
      endcase
   endfunction

   task automatic report_mismatch(input string sig, input logic [31:0] got,
                                  input logic [31:0] exp);
      err_cnt++;
      $display("[ERROR] %0t %s got %h exp %h", $time, sig, got, exp);
   endtask

   task automatic abort_on_timeout(input string what);
      timed_out = 1'b1;
      test_cnt++;
      fail_cnt++;
      $display("Timeout after %0d cycles: %s", WAIT_LIMIT, what);
   endtask

   // Sampled at posedge, checked at negedge when everything is settled
   always @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         accepted_q <= 1'b0;
         valid_q    <= 1'b0;
         bit_cnt    <= 6'd32;  // No stream pending
      end else begin
         accepted_q <= i_instr_stb & stb_expected;
         valid_q    <= o_imm_valid;
         if (i_instr_stb && stb_expected) begin
            bit_cnt <= '0;
         end else if (o_imm_valid) begin
            coll_imm[bit_cnt[4:0]] <= o_imm;
            if (bit_cnt < 6'd5)
               coll_zimm[bit_cnt[2:0]] <= o_csr_imm;
            bit_cnt <= bit_cnt + 6'd1;
         end
      end
   end

   assert property (@(negedge i_clk) !i_rst_n |-> {o_busy, o_addr_valid, o_imm_valid} == 3'b000)
      else report_mismatch("{o_busy,o_addr_valid,o_imm_valid}",
                           32'({o_busy, o_addr_valid, o_imm_valid}), 32'h0);
   assert property (@(negedge i_clk) disable iff (!i_rst_n) o_addr_valid == accepted_q)
      else report_mismatch("o_addr_valid", 32'(o_addr_valid), 32'(accepted_q));
   assert property (@(negedge i_clk) disable iff (!i_rst_n)
      o_busy == (accepted_q || bit_cnt < 6'd32))
      else report_mismatch("o_busy", 32'(o_busy), 32'(accepted_q || bit_cnt < 6'd32));
   assert property (@(negedge i_clk) disable iff (!i_rst_n) o_addr_valid |-> o_rs1_addr == exp_rs1)
      else report_mismatch("o_rs1_addr", 32'(o_rs1_addr), 32'(exp_rs1));
   assert property (@(negedge i_clk) disable iff (!i_rst_n) o_addr_valid |-> o_rs2_addr == exp_rs2)
      else report_mismatch("o_rs2_addr", 32'(o_rs2_addr), 32'(exp_rs2));
   assert property (@(negedge i_clk) disable iff (!i_rst_n) o_addr_valid |-> o_rd_addr == exp_rd)
      else report_mismatch("o_rd_addr", 32'(o_rd_addr), 32'(exp_rd));
   assert property (@(negedge i_clk) disable iff (!i_rst_n) o_addr_valid |=> o_imm_valid)
      else report_mismatch("o_imm_valid", 32'(o_imm_valid), 32'h1);
   assert property (@(negedge i_clk) disable iff (!i_rst_n)
      o_imm_valid && bit_cnt < 6'd32 && exp_mask[bit_cnt[4:0]] |-> o_imm == exp_imm[bit_cnt[4:0]])
      else report_mismatch($sformatf("o_imm bit %0d", bit_cnt), 32'(o_imm),
                           32'(exp_imm[bit_cnt[4:0]]));
   assert property (@(negedge i_clk) disable iff (!i_rst_n)
      o_imm_last == (o_imm_valid && bit_cnt == 6'd31))
      else report_mismatch("o_imm_last", 32'(o_imm_last), 32'(o_imm_valid && bit_cnt == 6'd31));
   assert property (@(negedge i_clk) disable iff (!i_rst_n)
      valid_q && !o_imm_valid |-> bit_cnt == 6'd32)
      else report_mismatch("o_imm_valid run length", 32'(bit_cnt), 32'd32);
   assert property (@(negedge i_clk) disable iff (!i_rst_n)
      csr_test && o_imm_valid && bit_cnt < 6'd5 |-> o_csr_imm == exp_zimm[bit_cnt[2:0]])
      else report_mismatch($sformatf("o_csr_imm bit %0d", bit_cnt), 32'(o_csr_imm),
                           32'(exp_zimm[bit_cnt[2:0]]));

   task automatic run_instr(input string name, input logic [6:0] opc, input logic [2:0] fmt,
                            input logic send_extra);
      serial_imm_pkg::instr_word_t w;
      logic [31:0] rnd;
      int          errs_before;
      int          t;
      if (timed_out)
         return;
      take_bits(32, rnd);
      w.raw      = rnd;
      w.r.opcode = opc;
      if (fmt == serial_imm_pkg::FMT_CSRI) begin
         w.raw[31]     = 1'b1;  // Sign set, must still stream as zero
         w.r.funct3[2] = 1'b1;
      end
      t = 0;
      while (o_busy && t < WAIT_LIMIT) begin
         @(negedge i_clk);
         t++;
      end
      if (o_busy) begin
         abort_on_timeout("unit still busy before a new strobe");
         return;
      end
      errs_before  = err_cnt;
      csr_test     = (fmt == serial_imm_pkg::FMT_CSRI);
      exp_mask     = csr_test ? 32'h8000_0000 : 32'hffff_ffff;
      exp_imm      = ref_imm(w, fmt);
      exp_zimm     = w.r.rs1;
      exp_rs1      = w.r.rs1;
      exp_rs2      = w.r.rs2;
      exp_rd       = w.r.rd;
      i_instr      = w.raw;
      i_instr_stb  = 1'b1;
      stb_expected = 1'b1;
      @(negedge i_clk);
      i_instr_stb  = 1'b0;
      stb_expected = 1'b0;
      if (send_extra) begin
         t = 0;
         while (bit_cnt < 6'd12 && t < WAIT_LIMIT) begin
            @(negedge i_clk);
            t++;
         end
         if (bit_cnt < 6'd12) begin
            abort_on_timeout("immediate stream did not reach bit 12");
            return;
         end
         i_instr     = ~w.raw;
         i_instr_stb = 1'b1;  // Arrives mid-stream
         @(negedge i_clk);
         i_instr_stb = 1'b0;
      end
      t = 0;
      while (o_busy && t < WAIT_LIMIT) begin
         @(negedge i_clk);
         t++;
      end
      if (o_busy) begin
         abort_on_timeout("o_busy never fell after the immediate stream");
         return;
      end
      assert (bit_cnt == 6'd32) else report_mismatch("o_imm_valid count", 32'(bit_cnt), 32'd32);
      assert ((coll_imm & exp_mask) == (exp_imm & exp_mask))
         else report_mismatch("o_imm stream", coll_imm & exp_mask, exp_imm & exp_mask);
      if (csr_test)
         assert (coll_zimm == exp_zimm) else report_mismatch("o_csr_imm", 32'(coll_zimm),
                                                             32'(exp_zimm));
      test_cnt++;
      if (err_cnt != errs_before)
         fail_cnt++;
      $display("%s instr %h imm %h : %s", name, w.raw, coll_imm,
               (err_cnt == errs_before) ? "ok" : "FAILED");
   endtask

   initial begin
      i_clk        = 1'b0;
      i_rst_n      = 1'b0;
      i_instr_stb  = 1'b0;
      i_instr      = '0;
      lfsr_state   = 16'd49593;
      exp_imm      = '0;
      exp_mask     = '0;
      exp_rs1      = '0;
      exp_rs2      = '0;
      exp_rd       = '0;
      exp_zimm     = '0;
      csr_test     = 1'b0;
      stb_expected = 1'b0;
      timed_out    = 1'b0;
      err_cnt      = 0;
      test_cnt     = 0;
      fail_cnt     = 0;
      repeat (8) @(negedge i_clk);
      i_rst_n = 1'b1;
      @(negedge i_clk);
      repeat (2) begin
         run_instr("OP-IMM", serial_imm_pkg::OPC_OPIMM, serial_imm_pkg::FMT_I, 1'b0);
         run_instr("LOAD", serial_imm_pkg::OPC_LOAD, serial_imm_pkg::FMT_I, 1'b0);
         run_instr("JALR", serial_imm_pkg::OPC_JALR, serial_imm_pkg::FMT_I, 1'b0);
         run_instr("STORE", serial_imm_pkg::OPC_STORE, serial_imm_pkg::FMT_S, 1'b0);
         run_instr("BRANCH", serial_imm_pkg::OPC_BRANCH, serial_imm_pkg::FMT_B, 1'b0);
         run_instr("LUI", serial_imm_pkg::OPC_LUI, serial_imm_pkg::FMT_U, 1'b0);
         run_instr("AUIPC", serial_imm_pkg::OPC_AUIPC, serial_imm_pkg::FMT_U, 1'b0);
         run_instr("JAL", serial_imm_pkg::OPC_JAL, serial_imm_pkg::FMT_J, 1'b0);
         run_instr("CSRI", serial_imm_pkg::OPC_SYSTEM, serial_imm_pkg::FMT_CSRI, 1'b0);
      end
      run_instr("OP-IMM busy strobe", serial_imm_pkg::OPC_OPIMM, serial_imm_pkg::FMT_I, 1'b1);
      run_instr("BRANCH busy strobe", serial_imm_pkg::OPC_BRANCH, serial_imm_pkg::FMT_B, 1'b1);
      $display("%0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0 && fail_cnt == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
